/* sim.f */
source/dcx_timing_pkg.sv
source/dcx_status_pkg.sv
source/input_sync.sv
source/event_counter.sv
source/event_readout.sv
source/reset_hold.sv
source/led_glow.sv
source/status_led_driver.sv
source/dcx_control_top.sv
tb/tb_dcx_control.sv

/* tb/control_vectors.txt */
// kind, video pulses, hdmi pulses, resync pulses, led_mode, expected (all hex)
// kind 1 reset, 2 events, 3 optional reset, 4 console reset, 5 pll lost, 6 ready, 7 glow
1 0 0 0 0 15
2 3 5 2 0 0
2 1 0 4 0 0
5 0 0 0 0 1
6 0 0 0 0 0
7 0 0 0 0 400
2 0 2 1 0 0
3 0 0 0 1 15
3 0 0 0 3 15
2 2 1 0 0 0
4 0 0 0 2 15
2 2 2 2 0 0
6 0 0 0 0 0
5 0 0 0 0 1
1 0 0 0 0 15
2 6 1 3 0 0
0 0 0 0 0 0

/* tb/tb_dcx_control.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcx_control;

    import dcx_status_pkg::*;
    import dcx_timing_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int FIELDS = 6;
    localparam int MAX_TESTS = 32;

    logic control_clock;
    logic reset_dc;
    logic reset_opt;
    logic video_pll_locked;
    logic hdmi_pll_locked;
    logic resync;
    logic force_generate;
    logic output_ready;
    logic [LED_MODE_WIDTH-1:0] led_mode;
    logic [SEL_WIDTH-1:0] count_sel;
    logic [COUNT_WIDTH-1:0] count_value;
    logic dc_nreset_pull;
    logic led_drive;
    logic led_level;

    // six words per test as laid out in the vector file
    logic [15:0] vectors [FIELDS*MAX_TESTS];
    logic [COUNT_WIDTH-1:0] model_count [NUM_EVENTS];
    logic channel_active [NUM_EVENTS];
    longint budget_cycles;
    bit budget_ready;

    dcx_control_top #(
        .hold_cycles(32'd20),
        .slow_glow_bit(10),
        .fast_glow_bit(9)
    ) dut (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .reset_opt(reset_opt),
        .video_pll_locked(video_pll_locked),
        .hdmi_pll_locked(hdmi_pll_locked),
        .resync(resync),
        .force_generate(force_generate),
        .output_ready(output_ready),
        .led_mode(led_mode),
        .count_sel(count_sel),
        .count_value(count_value),
        .dc_nreset_pull(dc_nreset_pull),
        .led_drive(led_drive),
        .led_level(led_level)
    );

    always #(CLK_PERIOD/2) control_clock = ~control_clock;

    ///////////////////////////////
    // reporting

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] actual,
                               input logic [COUNT_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            fail_run("event count mismatch");
        end
    endtask

    task automatic check_pin(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual,
                     expected);
            fail_run("pin level mismatch");
        end
    endtask

    ///////////////////////////////
    // stimulus entered on falling edges

    task automatic wait_edges(input int edges);
        repeat (edges) @(negedge control_clock);
    endtask

    // active means unlocked for the pll channels
    task automatic drive_channel(input int ch, input logic active);
        if (active && !channel_active[ch]) begin
            model_count[ch] = model_count[ch] + 1'b1;
        end
        channel_active[ch] = active;
        case (ch)
            EVT_VIDEO_PLL_UNLOCK: video_pll_locked = ~active;
            EVT_HDMI_PLL_UNLOCK: hdmi_pll_locked = ~active;
            default: resync = active;
        endcase
    endtask

    task automatic apply_reset();
        reset_dc = 1'b1;
        wait_edges(2);
        reset_dc = 1'b0;
        for (int ch = 0; ch < NUM_EVENTS; ch++) begin
            model_count[ch] = '0;
        end
    endtask

    task automatic send_pulses(input int ch, input int pulses);
        for (int p = 0; p < pulses; p++) begin
            drive_channel(ch, 1'b1);
            wait_edges($urandom_range(4, 1));
            drive_channel(ch, 1'b0);
            wait_edges($urandom_range(4, 1));
        end
    endtask

    // registered readout needs one edge per select value
    task automatic verify_counts(input logic [COUNT_WIDTH-1:0] unused_value);
        logic [COUNT_WIDTH-1:0] expected;
        for (int sel = 0; sel < 4; sel++) begin
            count_sel = SEL_WIDTH'(sel);
            wait_edges(1);
            expected = (sel < NUM_EVENTS) ? model_count[sel] : unused_value;
            check_count($sformatf("count_value[%0d]", sel), count_value, expected);
        end
    endtask

    // k counts edges after the last request edge
    task automatic watch_hold(input int hold_edges, input bit dc_held, input bit led_follows);
        for (int k = 1; k <= hold_edges + 3; k++) begin
            wait_edges(1);
            check_pin("dc_nreset_pull", dc_nreset_pull, dc_held && (k < hold_edges));
            if (led_follows) begin
                check_pin("led_drive", led_drive, k <= hold_edges);
                check_pin("led_level", led_level, 1'b0);
            end
        end
    endtask

    task automatic check_level_steady(input logic expected);
        wait_edges(4);
        for (int k = 0; k < 8; k++) begin
            check_pin("led_drive", led_drive, 1'b1);
            check_pin("led_level", led_level, expected);
            wait_edges(1);
        end
    endtask

    task automatic watch_glow(input int window);
        bit seen_low;
        bit seen_high;
        seen_low = 1'b0;
        seen_high = 1'b0;
        wait_edges(4);
        for (int k = 0; k < window; k++) begin
            if (led_level) begin
                seen_high = 1'b1;
            end else begin
                seen_low = 1'b1;
            end
            wait_edges(1);
        end
        if (!(seen_low && seen_high)) begin
            fail_run("led_level did not take both values during resync");
        end
    endtask

    ///////////////////////////////
    // test sequencing

    function automatic longint test_cycles(input int base);
        case (vectors[base])
            16'd2: return longint'(vectors[base+1]) + vectors[base+2] + vectors[base+3]
                          + 2 + longint'(vectors[base+1] + vectors[base+2]) * 9
                          + longint'(vectors[base+3]) * 9 + 20;
            16'd5, 16'd6: return 30;
            default: return longint'(vectors[base+5]) + 20;
        endcase
    endfunction

    task automatic run_test(input int base);
        logic [15:0] kind;
        logic [15:0] expected;
        kind = vectors[base];
        expected = vectors[base+5];
        led_mode = vectors[base+4][LED_MODE_WIDTH-1:0];
        case (kind)
            16'd1: begin
                apply_reset();
                watch_hold(expected, 1'b1, 1'b0);
                verify_counts('0);
            end
            16'd2: begin
                for (int ch = 0; ch < NUM_EVENTS; ch++) begin
                    send_pulses(ch, vectors[base+1+ch]);
                end
                wait_edges(5);
                verify_counts(COUNT_WIDTH'(expected));
            end
            16'd3: begin
                reset_opt = 1'b1;
                wait_edges(1);
                reset_opt = 1'b0;
                watch_hold(expected, 1'b0, 1'b1);
            end
            16'd4: begin
                apply_reset();
                watch_hold(expected, 1'b1, 1'b1);
            end
            16'd5: begin
                drive_channel(EVT_HDMI_PLL_UNLOCK, 1'b1);
                check_level_steady(expected[0]);
                drive_channel(EVT_HDMI_PLL_UNLOCK, 1'b0);
                wait_edges(4);
            end
            16'd6: begin
                output_ready = 1'b1;
                check_level_steady(expected[0]);
                output_ready = 1'b0;
            end
            16'd7: begin
                drive_channel(EVT_RESYNC, 1'b1);
                watch_glow(expected);
                drive_channel(EVT_RESYNC, 1'b0);
                wait_edges(4);
            end
            default: fail_run("unknown test kind in the vector file");
        endcase
    endtask

    initial begin
        int test_index;
        control_clock = 1'b0;
        reset_dc = 1'b1;
        reset_opt = 1'b0;
        video_pll_locked = 1'b1;
        hdmi_pll_locked = 1'b1;
        resync = 1'b0;
        force_generate = 1'b0;
        output_ready = 1'b0;
        led_mode = LED_MODE_STATUS;
        count_sel = '0;
        budget_ready = 1'b0;
        for (int ch = 0; ch < NUM_EVENTS; ch++) begin
            channel_active[ch] = 1'b0;
        end
        void'($urandom(32'h7063_9ada));
        $readmemh("tb/control_vectors.txt", vectors);
        if ($isunknown(vectors[0])) begin
            fail_run("vector file could not be read");
        end

        // cycle budget tripled for the watchdog
        budget_cycles = 40;
        test_index = 0;
        while (test_index < MAX_TESTS && vectors[test_index*FIELDS] !== 16'h0) begin
            budget_cycles = budget_cycles + test_cycles(test_index * FIELDS);
            test_index++;
        end
        budget_cycles = budget_cycles * 3;
        budget_ready = 1'b1;

        apply_reset();
        test_index = 0;
        while (test_index < MAX_TESTS && vectors[test_index*FIELDS] !== 16'h0) begin
            run_test(test_index * FIELDS);
            test_index++;
        end

        $display("TESTS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        wait (budget_ready);
        #(budget_cycles * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

/* source/dcx_control_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcx_control_top #(
    parameter logic [31:0] hold_cycles = dcx_timing_pkg::RESET_HOLD_CYCLES,
    parameter int slow_glow_bit = dcx_timing_pkg::SLOW_GLOW_BIT,
    parameter int fast_glow_bit = dcx_timing_pkg::FAST_GLOW_BIT
) (
    input wire control_clock,
    input wire reset_dc,
    input wire reset_opt,
    input wire video_pll_locked,
    input wire hdmi_pll_locked,
    input wire resync,
    input wire force_generate,
    input wire output_ready,
    input wire [dcx_status_pkg::LED_MODE_WIDTH-1:0] led_mode,
    input wire [dcx_status_pkg::SEL_WIDTH-1:0] count_sel,
    output logic [dcx_timing_pkg::COUNT_WIDTH-1:0] count_value,
    output logic dc_nreset_pull,
    output logic led_drive,
    output logic led_level
);

    import dcx_status_pkg::*;
    import dcx_timing_pkg::*;

    logic [NUM_EVENTS-1:0] event_request;
    logic [NUM_EVENTS*COUNT_WIDTH-1:0] count_bus;
    logic hdmi_pll_ready;
    logic resync_active;
    logic force_generate_active;
    logic opt_request;
    logic opt_hold;
    logic slow_glow;
    logic fast_glow;

    input_sync u_input_sync (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .video_pll_locked(video_pll_locked),
        .hdmi_pll_locked(hdmi_pll_locked),
        .resync(resync),
        .force_generate(force_generate),
        .event_request(event_request),
        .hdmi_pll_ready(hdmi_pll_ready),
        .resync_active(resync_active),
        .force_generate_active(force_generate_active)
    );

    ///////////////////////////////
    // event counting
    for (genvar ch = 0; ch < NUM_EVENTS; ch++) begin : gen_event
        event_counter u_event_counter (
            .control_clock(control_clock),
            .reset_dc(reset_dc),
            .event_request(event_request[ch]),
            .count(count_bus[ch*COUNT_WIDTH +: COUNT_WIDTH])
        );
    end

    event_readout u_event_readout (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .count_bus(count_bus),
        .count_sel(count_sel),
        .count_value(count_value)
    );

    ///////////////////////////////
    // reset timers
    reset_hold #(.hold_cycles(hold_cycles)) u_dc_hold (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .hold_active(dc_nreset_pull)
    );

    // optional line also restarts with the console
    assign opt_request = reset_opt | reset_dc;

    reset_hold #(.hold_cycles(hold_cycles)) u_opt_hold (
        .control_clock(control_clock),
        .reset_dc(opt_request),
        .hold_active(opt_hold)
    );

    ///////////////////////////////
    // status led
    led_glow #(.top_bit(slow_glow_bit)) u_slow_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(slow_glow)
    );

    led_glow #(.top_bit(fast_glow_bit)) u_fast_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(fast_glow)
    );

    status_led_driver u_status_led_driver (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .led_mode(led_mode),
        .hdmi_pll_ready(hdmi_pll_ready),
        .resync_active(resync_active),
        .force_generate_active(force_generate_active),
        .output_ready(output_ready),
        .slow_glow(slow_glow),
        .fast_glow(fast_glow),
        .dc_hold(dc_nreset_pull),
        .opt_hold(opt_hold),
        .led_drive(led_drive),
        .led_level(led_level)
    );

endmodule

`default_nettype wire

/* source/status_led_driver.sv */
`timescale 1ns/1ns
`default_nettype none

module status_led_driver (
    input wire control_clock,
    input wire reset_dc,
    input wire [dcx_status_pkg::LED_MODE_WIDTH-1:0] led_mode,
    input wire hdmi_pll_ready,
    input wire resync_active,
    input wire force_generate_active,
    input wire output_ready,
    input wire slow_glow,
    input wire fast_glow,
    input wire dc_hold,
    input wire opt_hold,
    output logic led_drive,
    output logic led_level
);

    import dcx_status_pkg::*;
    import dcx_timing_pkg::*;

    // blink period of four fast glow cycles
    logic [FAST_GLOW_BIT+2:0] blink_count;
    logic health_level;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    ///////////////////////////////
    // health indication, led is active low
    always_comb begin
        if (!hdmi_pll_ready) begin
            health_level = 1'b1;
        end else if (resync_active) begin
            health_level = ~fast_glow;
        end else if (force_generate_active) begin
            health_level = blink_count[$high(blink_count)] ? ~fast_glow : 1'b1;
        end else if (output_ready) begin
            health_level = 1'b0;
        end else begin
            health_level = ~slow_glow;
        end
    end

    ///////////////////////////////
    // pin mux
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_drive <= 1'b1;
            led_level <= 1'b1;
        end else if (led_mode == LED_MODE_STATUS) begin
            led_drive <= 1'b1;
            led_level <= health_level;
        end else if (led_mode == LED_MODE_DC_RESET) begin
            // pull low while the console reset is held
            led_drive <= dc_hold;
            led_level <= 1'b0;
        end else begin
            led_drive <= opt_hold;
            led_level <= 1'b0;
        end
    end

    // pin follows the console hold one edge late
    dc_mirror_check : assert property (
        @(posedge control_clock)
        (led_mode == LED_MODE_DC_RESET) && !reset_dc |=> led_drive == $past(dc_hold)
    );

endmodule

`default_nettype wire

/* source/led_glow.sv */
`timescale 1ns/1ns
`default_nettype none

module led_glow #(
    parameter int top_bit = dcx_timing_pkg::SLOW_GLOW_BIT
) (
    input wire control_clock,
    input wire reset_dc,
    output logic glow
);

    logic [top_bit:0] glow_count;
    logic [7:0] ramp;
    logic [7:0] brightness;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
        end else begin
            glow_count <= glow_count + 1'b1;
        end
    end

    // top bit picks the ramp direction
    assign ramp = glow_count[top_bit-1 -: 8];
    assign brightness = glow_count[top_bit] ? ~ramp : ramp;

    // pwm against the low byte
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow <= 1'b0;
        end else begin
            glow <= glow_count[7:0] < brightness;
        end
    end

endmodule

`default_nettype wire

/* source/reset_hold.sv */
`timescale 1ns/1ns
`default_nettype none

module reset_hold #(
    parameter logic [31:0] hold_cycles = dcx_timing_pkg::RESET_HOLD_CYCLES
) (
    input wire control_clock,
    input wire reset_dc,
    output logic hold_active
);

    logic [31:0] hold_count;

    // request restarts the count and asserts the line
    // count parks once the line is released
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= '0;
            hold_active <= 1'b1;
        end else if (hold_active) begin
            hold_count <= hold_count + 1'b1;
            if (hold_count == hold_cycles) begin
                hold_active <= 1'b0;
            end
        end
    end

    ///////////////////////////////
    // checks

    // the line only comes back after a request
    hold_rise_check : assert property (
        @(posedge control_clock) $rose(hold_active) |-> $past(reset_dc)
    );

endmodule

`default_nettype wire

/* source/event_readout.sv */
`timescale 1ns/1ns
`default_nettype none

module event_readout (
    input wire control_clock,
    input wire reset_dc,
    input wire [dcx_status_pkg::NUM_EVENTS*dcx_timing_pkg::COUNT_WIDTH-1:0] count_bus,
    input wire [dcx_status_pkg::SEL_WIDTH-1:0] count_sel,
    output logic [dcx_timing_pkg::COUNT_WIDTH-1:0] count_value
);

    import dcx_status_pkg::*;
    import dcx_timing_pkg::*;

    logic [COUNT_WIDTH-1:0] selected;

    // unused indices fall through to zero
    always_comb begin
        selected = '0;
        for (int i = 0; i < NUM_EVENTS; i++) begin
            if (count_sel == i) begin
                selected = count_bus[i*COUNT_WIDTH +: COUNT_WIDTH];
            end
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count_value <= '0;
        end else begin
            count_value <= selected;
        end
    end

endmodule

`default_nettype wire

/* source/event_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module event_counter (
    input wire control_clock,
    input wire reset_dc,
    input wire event_request,
    output logic [dcx_timing_pkg::COUNT_WIDTH-1:0] count
);

    logic request_prev;
    logic request_rise;

    // rising edge of the synchronised level
    assign request_rise = event_request & ~request_prev;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            request_prev <= 1'b0;
        end else begin
            request_prev <= event_request;
        end
    end

    // wraps at full width
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
        end else if (request_rise) begin
            count <= count + 1'b1;
        end
    end

    ///////////////////////////////
    // checks

    // outside reset the count only holds or steps up by one
    count_step_check : assert property (
        @(posedge control_clock)
        !reset_dc |=> (count == $past(count)) || (count == $past(count) + 1'b1)
    );

endmodule

`default_nettype wire

/* source/input_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module input_sync (
    input wire control_clock,
    input wire reset_dc,
    input wire video_pll_locked,
    input wire hdmi_pll_locked,
    input wire resync,
    input wire force_generate,
    output logic [dcx_status_pkg::NUM_EVENTS-1:0] event_request,
    output logic hdmi_pll_ready,
    output logic resync_active,
    output logic force_generate_active
);

    import dcx_status_pkg::*;
    import dcx_timing_pkg::*;

    // event channels plus force-generate on top
    localparam int SYNC_WIDTH = NUM_EVENTS + 1;
    localparam int FORCE_BIT = NUM_EVENTS;

    logic [SYNC_WIDTH-1:0] sync_in;
    logic [SYNC_WIDTH-1:0] sync_q [SYNC_STAGES];

    // lock levels enter as unlock requests
    always_comb begin
        sync_in = '0;
        sync_in[EVT_VIDEO_PLL_UNLOCK] = ~video_pll_locked;
        sync_in[EVT_HDMI_PLL_UNLOCK] = ~hdmi_pll_locked;
        sync_in[EVT_RESYNC] = resync;
        sync_in[FORCE_BIT] = force_generate;
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= sync_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // every output taps the last stage
    assign event_request = sync_q[SYNC_STAGES-1][NUM_EVENTS-1:0];
    assign hdmi_pll_ready = ~sync_q[SYNC_STAGES-1][EVT_HDMI_PLL_UNLOCK];
    assign resync_active = sync_q[SYNC_STAGES-1][EVT_RESYNC];
    assign force_generate_active = sync_q[SYNC_STAGES-1][FORCE_BIT];

endmodule

`default_nettype wire

/* source/dcx_status_pkg.sv */
`default_nettype none

package dcx_status_pkg;

    // event channels, also the count_sel values
    localparam int NUM_EVENTS = 3;
    localparam int EVT_VIDEO_PLL_UNLOCK = 0;
    localparam int EVT_HDMI_PLL_UNLOCK = 1;
    localparam int EVT_RESYNC = 2;

    localparam int SEL_WIDTH = 2;

    ///////////////////////////////
    // status led pin modes
    localparam int LED_MODE_WIDTH = 2;

    // converter health on the pin
    localparam logic [LED_MODE_WIDTH-1:0] LED_MODE_STATUS = 2'd0;
    // mirror the console reset
    localparam logic [LED_MODE_WIDTH-1:0] LED_MODE_DC_RESET = 2'd2;
    // any other code mirrors the optional reset

endpackage

`default_nettype wire

/* source/dcx_timing_pkg.sv */
`default_nettype none

package dcx_timing_pkg;

    // cycles a reset line stays asserted after its request
    localparam logic [31:0] RESET_HOLD_CYCLES = 32'd32_000_000;

    // top counter bit of each glow generator
    localparam int SLOW_GLOW_BIT = 26;
    localparam int FAST_GLOW_BIT = 22;

    // width of every event count
    localparam int COUNT_WIDTH = 32;

    // flops per asynchronous input
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire
